// ==== vlog.f ====
+incdir+include
source/dcore_pkg.sv
source/cfg_regs.sv
source/adc_unfold.sv
source/bit_slicer.sv
source/prbs_gen.sv
source/prbs_check.sv
source/rx_dcore.sv
bench/tb_rx_dcore.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the rx_dcore testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rx_dcore \
    -f vlog.f \
    -Mdir obj_dir \
    -o sim_rx_dcore

./obj_dir/sim_rx_dcore | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi

// ==== bench/tb_rx_dcore.sv ====
`default_nettype none

`include "dcore_settings.svh"

module tb_rx_dcore;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int CODE_MAX    = (1 << (`NADC - 1)) - 1;
    localparam int CODE_MIN    = -(1 << (`NADC - 1));

    // rough cycle budget of each test
    localparam int TEST1_CYCLES   = 20;
    localparam int TEST2_CYCLES   = 140;
    localparam int TEST3_CYCLES   = 100;
    localparam int TEST4_CYCLES   = 70;
    localparam int TEST5_CYCLES   = 60;
    localparam int TEST6_CYCLES   = 20;
    localparam int TIMEOUT_CYCLES = 2 * (TEST1_CYCLES + TEST2_CYCLES + TEST3_CYCLES
                                         + TEST4_CYCLES + TEST5_CYCLES + TEST6_CYCLES);

    logic                     clk_adc;
    logic                     reset_i;
    logic                     cfg_req_i;
    dcore_pkg::cfg_cmd_t      cfg_cmd_i;
    logic                     cfg_ack_o;
    dcore_pkg::raw_frame_t    adc_i;
    dcore_pkg::code_frame_t   codes_o;
    dcore_pkg::check_counts_t counts_o;

    logic [31:0]            lfsr_state;
    logic [`PRBS_ORDER-1:0] prbs_state;
    logic                   prbs_signs;
    dcore_pkg::adc_code_t   model_offset;
    logic                   adc_win;
    logic                   adc_done;
    logic                   bist_win;
    logic                   inj_win;
    logic                   inj_done;
    int                     fail_count;
    int                     test_fails_start;
    int                     tests_done;
    int                     injects_sent;
    int                     cycle_count;

    rx_dcore i_rx_dcore (
        .clk_adc   (clk_adc),
        .reset_i   (reset_i),
        .cfg_req_i (cfg_req_i),
        .cfg_cmd_i (cfg_cmd_i),
        .cfg_ack_o (cfg_ack_o),
        .adc_i     (adc_i),
        .codes_o   (codes_o),
        .counts_o  (counts_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adc = ~clk_adc;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // x^7+x^6+1, new bit lands in bit 0
    function automatic logic [`PRBS_ORDER-1:0] prbs7_next(input logic [`PRBS_ORDER-1:0] s);
        return {s[`PRBS_ORDER-2:0], s[`PRBS_ORDER-1] ^ s[`PRBS_ORDER-2]};
    endfunction

    // reference unfold in plain integer math
    function automatic dcore_pkg::code_frame_t expect_codes(
        input dcore_pkg::raw_frame_t f,
        input dcore_pkg::adc_code_t  off
    );
        dcore_pkg::code_frame_t e;
        int                     v;
        for (int k = 0; k < `NTI; k++) begin
            v = int'(f.slice[k].mag);
            if (!f.slice[k].sign) begin
                v = -v;
            end
            v = v - int'(off);
            if (v > CODE_MAX) begin
                v = CODE_MAX;
            end else if (v < CODE_MIN) begin
                v = CODE_MIN;
            end
            e.code[k] = v[`NADC-1:0];
        end
        e.valid = f.valid;
        return e;
    endfunction

    task automatic report_fail(input string msg);
        fail_count++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_frame();
        dcore_pkg::raw_frame_t f;
        logic [31:0]           r;
        f = '0;
        take_bits(2, r);
        f.valid = (r[1:0] != 2'b00);
        for (int k = 0; k < `NTI; k++) begin
            take_bits(`NADC, r);
            f.slice[k].mag = r[`NADC-1:0];
            if (prbs_signs) begin
                // zero magnitude would slice to 0 whatever the sign
                if (f.slice[k].mag == '0) begin
                    f.slice[k].mag = `NADC'(1);
                end
                if (f.valid) begin
                    prbs_state = prbs7_next(prbs_state);
                    f.slice[k].sign = prbs_state[0];
                end
            end else begin
                take_bits(1, r);
                f.slice[k].sign = r[0];
            end
        end
        adc_i = f;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_adc);
        end
        #DRIVE_DELAY;
    endtask

    // one four-phase transfer, returns once ack has fallen
    task automatic send_cmd(
        input dcore_pkg::cfg_op_e            op,
        input logic [`CFG_DATA_WIDTH-1:0]    data
    );
        cfg_cmd_i.op   = op;
        cfg_cmd_i.data = data;
        cfg_req_i      = 1'b1;
        wait_cycles(1);
        while (!cfg_ack_o) begin
            wait_cycles(1);
        end
        // command took effect on the edge that raised ack
        if (op == dcore_pkg::CFG_SET_OFFSET) begin
            model_offset = data[`NADC-1:0];
        end
        if (op == dcore_pkg::CFG_INJECT_ERR) begin
            injects_sent++;
        end
        cfg_req_i = 1'b0;
        wait_cycles(1);
        while (cfg_ack_o) begin
            wait_cycles(1);
        end
    endtask

    task automatic unfold_with_offset(input logic [`CFG_DATA_WIDTH-1:0] off);
        send_cmd(dcore_pkg::CFG_SET_OFFSET, off);
        wait_cycles(20);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s: %0d failed checks", tests_done, name,
                 fail_count - test_fails_start);
        test_fails_start = fail_count;
    endtask

    always @(posedge clk_adc) begin
        #DRIVE_DELAY;
        drive_frame();
    end

    always @(posedge clk_adc) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d clock cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    ack_low_after_reset: assert property (
        @(posedge clk_adc) ($past(reset_i) && !reset_i) |-> !cfg_ack_o
    ) else report_fail("cfg_ack_o high right after reset");

    ack_rises_after_req: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (!$past(reset_i) && $past(cfg_req_i) && !$past(cfg_ack_o)) |-> cfg_ack_o
    ) else report_fail("cfg_ack_o did not rise one clock after cfg_req_i");

    ack_falls_after_req: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (!$past(reset_i) && !$past(cfg_req_i) && $past(cfg_ack_o)) |-> !cfg_ack_o
    ) else report_fail("cfg_ack_o did not fall one clock after cfg_req_i");

    ack_holds: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (!$past(reset_i) && $past(cfg_req_i) == $past(cfg_ack_o))
        |-> cfg_ack_o == $past(cfg_ack_o)
    ) else report_fail("cfg_ack_o moved without a change on cfg_req_i");

    unfold_matches: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        !$past(reset_i) |-> codes_o == expect_codes($past(adc_i), $past(model_offset))
    ) else report_fail("codes_o differs from the unfolded adc_i frame");

    adc_no_errors: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        adc_win |-> counts_o.err_count == '0
    ) else report_fail("err_count nonzero on the ADC path");

    adc_total_steps: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (adc_win && $past(adc_win))
        |-> (counts_o.total_count == $past(counts_o.total_count)
             || counts_o.total_count == $past(counts_o.total_count) + `COUNT_WIDTH'(`NTI))
    ) else report_fail("total_count did not step by 0 or NTI on the ADC path");

    adc_total_grew: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        adc_done |-> counts_o.total_count != '0
    ) else report_fail("total_count never grew on the ADC path");

    bist_no_errors: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        bist_win |-> counts_o.err_count == '0
    ) else report_fail("err_count nonzero on the BIST path");

    bist_total_steps: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (bist_win && $past(bist_win))
        |-> counts_o.total_count == $past(counts_o.total_count) + `COUNT_WIDTH'(`NTI)
    ) else report_fail("total_count did not grow by NTI on the BIST path");

    // error count lands three clocks after the ack edge
    inject_adds_three: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (inj_win && $past(cfg_ack_o, 2) && !$past(cfg_ack_o, 3)
         && $past(cfg_cmd_i.op, 3) == dcore_pkg::CFG_INJECT_ERR)
        |-> counts_o.err_count == $past(counts_o.err_count) + `COUNT_WIDTH'(3)
    ) else report_fail("injected error did not add exactly 3 to err_count");

    no_error_without_inject: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (inj_win && $past(inj_win) && !($past(cfg_ack_o, 2) && !$past(cfg_ack_o, 3)))
        |-> counts_o.err_count == $past(counts_o.err_count)
    ) else report_fail("err_count moved without an injected error");

    inject_total: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        inj_done |-> counts_o.err_count == `COUNT_WIDTH'(3 * injects_sent)
    ) else report_fail("err_count is not three per injected error");

    clear_zeroes_counts: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (!$past(reset_i) && $past(cfg_ack_o) && !$past(cfg_ack_o, 2)
         && $past(cfg_cmd_i.op, 2) == dcore_pkg::CFG_CLEAR_COUNTS)
        |-> (counts_o.err_count == '0 && counts_o.total_count == '0)
    ) else report_fail("counts not zero on the cycle after a clear");

    initial begin
        reset_i          = 1'b1;
        cfg_req_i        = 1'b0;
        cfg_cmd_i        = '0;
        adc_i            = '0;
        lfsr_state       = 32'h1957;
        prbs_state       = '1;
        prbs_signs       = 1'b0;
        model_offset     = '0;
        adc_win          = 1'b0;
        adc_done         = 1'b0;
        bist_win         = 1'b0;
        inj_win          = 1'b0;
        inj_done         = 1'b0;
        fail_count       = 0;
        test_fails_start = 0;
        tests_done       = 0;
        injects_sent     = 0;
        cycle_count      = 0;

        repeat (2) begin
            @(posedge clk_adc);
        end
        #DRIVE_DELAY;
        reset_i = 1'b0;

        // config port handshakes
        wait_cycles(2);
        send_cmd(dcore_pkg::CFG_SET_THRESH, '0);
        send_cmd(dcore_pkg::CFG_CHECK_EN, '0);
        finish_test("config handshake");

        // random frames, offsets that saturate at both ends
        unfold_with_offset(16'h0000);
        unfold_with_offset(16'h0080);
        unfold_with_offset(16'h007f);
        unfold_with_offset(16'h00c0);
        unfold_with_offset(16'h0025);
        finish_test("unfold and saturation");

        send_cmd(dcore_pkg::CFG_SET_OFFSET, '0);
        send_cmd(dcore_pkg::CFG_SET_THRESH, '0);
        send_cmd(dcore_pkg::CFG_SET_SOURCE, `CFG_DATA_WIDTH'(dcore_pkg::SRC_ADC));
        prbs_signs = 1'b1;
        // let the random frames drain from the pipeline
        wait_cycles(4);
        adc_win = 1'b1;
        send_cmd(dcore_pkg::CFG_CHECK_EN, `CFG_DATA_WIDTH'(1));
        wait_cycles(60);
        adc_done = 1'b1;
        wait_cycles(1);
        adc_done = 1'b0;
        adc_win  = 1'b0;
        finish_test("adc path check");

        send_cmd(dcore_pkg::CFG_CHECK_EN, '0);
        send_cmd(dcore_pkg::CFG_SET_SOURCE, `CFG_DATA_WIDTH'(dcore_pkg::SRC_BIST));
        send_cmd(dcore_pkg::CFG_CLEAR_COUNTS, '0);
        send_cmd(dcore_pkg::CFG_CHECK_EN, `CFG_DATA_WIDTH'(1));
        wait_cycles(3);
        bist_win = 1'b1;
        wait_cycles(30);
        bist_win = 1'b0;
        finish_test("bist path check");

        inj_win = 1'b1;
        repeat (4) begin
            send_cmd(dcore_pkg::CFG_INJECT_ERR, '0);
            wait_cycles(8);
        end
        inj_done = 1'b1;
        wait_cycles(1);
        inj_done = 1'b0;
        inj_win  = 1'b0;
        finish_test("error injection");

        // counts are nonzero here
        send_cmd(dcore_pkg::CFG_CLEAR_COUNTS, '0);
        wait_cycles(4);
        finish_test("clear counts");

        $display("%0d tests run, %0d failed checks", tests_done, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/rx_dcore.sv ====
`default_nettype none

module rx_dcore (
    input  wire logic                     clk_adc,
    input  wire logic                     reset_i,
    input  wire logic                     cfg_req_i,
    input  wire dcore_pkg::cfg_cmd_t      cfg_cmd_i,
    output wire logic                     cfg_ack_o,
    input  wire dcore_pkg::raw_frame_t    adc_i,
    output wire dcore_pkg::code_frame_t   codes_o,
    output wire dcore_pkg::check_counts_t counts_o
);

    wire dcore_pkg::dcore_ctrl_t ctrl;
    wire dcore_pkg::bit_frame_t  adc_bits;
    wire dcore_pkg::bit_frame_t  bist_bits;

    // configuration port, stands in for the register bank
    cfg_regs i_cfg_regs (
        .clk_adc   (clk_adc),
        .reset_i   (reset_i),
        .cfg_req_i (cfg_req_i),
        .cfg_cmd_i (cfg_cmd_i),
        .cfg_ack_o (cfg_ack_o),
        .ctrl_o    (ctrl)
    );

    // stage 1, codes leave the chip from here
    adc_unfold i_adc_unfold (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .adc_i    (adc_i),
        .offset_i (ctrl.offset),
        .codes_o  (codes_o)
    );

    // stage 2
    bit_slicer i_bit_slicer (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .codes_i  (codes_o),
        .thresh_i (ctrl.threshold),
        .bits_o   (adc_bits)
    );

    // BIST source
    prbs_gen i_prbs_gen (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .inject_i (ctrl.inject),
        .bits_o   (bist_bits)
    );

    // stage 3, counts
    prbs_check i_prbs_check (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .adc_bits_i  (adc_bits),
        .bist_bits_i (bist_bits),
        .source_i    (ctrl.source),
        .check_en_i  (ctrl.check_en),
        .clear_i     (ctrl.clear),
        .counts_o    (counts_o)
    );

endmodule

`default_nettype wire

// ==== source/prbs_check.sv ====
`default_nettype none

`include "dcore_settings.svh"

module prbs_check (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire dcore_pkg::bit_frame_t adc_bits_i,
    input  wire dcore_pkg::bit_frame_t bist_bits_i,
    input  wire dcore_pkg::prbs_src_e  source_i,
    input  wire logic                  check_en_i,
    input  wire logic                  clear_i,
    output dcore_pkg::check_counts_t   counts_o
);

    localparam int NHIST = `PRBS_ORDER;
    localparam int CW    = `COUNT_WIDTH;
    localparam int PW    = $clog2(`NTI + 1);

    dcore_pkg::bit_frame_t sel;
    logic [NHIST-1:0]      hist_q;
    logic                  hist_valid_q;
    logic [`NTI+NHIST-1:0] seq;
    dcore_pkg::bit_word_t  err_bits;
    logic [PW-1:0]         err_num;
    logic                  check_now;
    logic [CW-1:0]         err_q;
    logic [CW-1:0]         total_q;

    assign sel = (source_i == dcore_pkg::SRC_BIST) ? bist_bits_i : adc_bits_i;

    // serial order, seq[0] is the oldest history bit
    assign seq = {sel.bits, hist_q};

    // bit n predicted from bits n-7 and n-6
    always_comb begin
        err_num = '0;
        for (int k = 0; k < `NTI; k++) begin
            err_bits[k] = sel.bits[k] ^ seq[k] ^ seq[k+1];
            err_num     = err_num + PW'(err_bits[k]);
        end
    end

    // first word after enable only loads the history
    assign check_now = sel.valid && check_en_i && hist_valid_q;

    always_ff @(posedge clk_adc) begin
        if (reset_i || !check_en_i) begin
            hist_valid_q <= 1'b0;
        end else if (sel.valid) begin
            hist_valid_q <= 1'b1;
        end
    end

    // last NHIST bits of the accepted word
    always_ff @(posedge clk_adc) begin
        if (sel.valid) begin
            hist_q <= sel.bits[`NTI-1 -: NHIST];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i || clear_i) begin
            err_q   <= '0;
            total_q <= '0;
        end else if (check_now) begin
            err_q   <= err_q + CW'(err_num);
            total_q <= total_q + CW'(`NTI);
        end
    end

    assign counts_o.err_count   = err_q;
    assign counts_o.total_count = total_q;

    // every error bit was also counted as a checked bit
    err_within_total: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        counts_o.err_count <= counts_o.total_count
    );

endmodule

`default_nettype wire

// ==== source/prbs_gen.sv ====
`default_nettype none

`include "dcore_settings.svh"

module prbs_gen (
    input  wire logic             clk_adc,
    input  wire logic             reset_i,
    input  wire logic             inject_i,
    output dcore_pkg::bit_frame_t bits_o
);

    // state[0] is the most recent bit, state[ORDER-1] the oldest
    localparam int ORDER = `PRBS_ORDER;

    logic [ORDER-1:0]     state_q;
    logic [ORDER-1:0]     state_d;
    dcore_pkg::bit_word_t word_d;
    dcore_pkg::bit_word_t word_q;
    logic                 valid_q;

    // unroll NTI serial steps of x^7+x^6+1
    always_comb begin
        state_d = state_q;
        for (int i = 0; i < `NTI; i++) begin
            word_d[i] = state_d[ORDER-1] ^ state_d[ORDER-2];
            state_d   = {state_d[ORDER-2:0], word_d[i]};
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            state_q <= '1;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= 1'b1;
        end
    end

    // injected error flips the earliest bit of one word, state is untouched
    always_ff @(posedge clk_adc) begin
        word_q <= word_d ^ `NTI'(inject_i);
    end

    assign bits_o.bits  = word_q;
    assign bits_o.valid = valid_q;

    state_never_zero: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        state_q != '0
    );

endmodule

`default_nettype wire

// ==== source/bit_slicer.sv ====
`default_nettype none

`include "dcore_settings.svh"

module bit_slicer (
    input  wire logic                   clk_adc,
    input  wire logic                   reset_i,
    input  wire dcore_pkg::code_frame_t codes_i,
    input  wire dcore_pkg::adc_code_t   thresh_i,
    output dcore_pkg::bit_frame_t       bits_o
);

    dcore_pkg::bit_word_t bits_d;
    dcore_pkg::bit_word_t bits_q;
    logic                 valid_q;

    // signed compare, a code equal to the threshold slices to 0
    always_comb begin
        for (int k = 0; k < `NTI; k++) begin
            bits_d[k] = $signed(codes_i.code[k]) > $signed(thresh_i);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= codes_i.valid;
        end
    end

    always_ff @(posedge clk_adc) begin
        bits_q <= bits_d;
    end

    assign bits_o.bits  = bits_q;
    assign bits_o.valid = valid_q;

endmodule

`default_nettype wire

// ==== source/adc_unfold.sv ====
`default_nettype none

`include "dcore_settings.svh"

module adc_unfold (
    input  wire logic                   clk_adc,
    input  wire logic                   reset_i,
    input  wire dcore_pkg::raw_frame_t  adc_i,
    input  wire dcore_pkg::adc_code_t   offset_i,
    output dcore_pkg::code_frame_t      codes_o
);

    // two guard bits cover the magnitude sign and the offset subtraction
    localparam int WIDE = `NADC + 2;
    localparam logic signed [WIDE-1:0] CODE_MAX = WIDE'((2 ** (`NADC - 1)) - 1);
    localparam logic signed [WIDE-1:0] CODE_MIN = -WIDE'(2 ** (`NADC - 1));

    dcore_pkg::adc_code_t [`NTI-1:0] code_q;
    logic                            valid_q;

    function automatic dcore_pkg::adc_code_t unfold_slice(
        input dcore_pkg::raw_slice_t s,
        input dcore_pkg::adc_code_t  offset
    );
        logic signed [WIDE-1:0] mag_w;
        logic signed [WIDE-1:0] off_w;
        logic signed [WIDE-1:0] val_w;
        mag_w = $signed({2'b00, s.mag});
        off_w = $signed({{2{offset[`NADC-1]}}, offset});
        // sign 1 means a positive sample
        val_w = s.sign ? mag_w : -mag_w;
        val_w = val_w - off_w;
        if (val_w > CODE_MAX) begin
            val_w = CODE_MAX;
        end else if (val_w < CODE_MIN) begin
            val_w = CODE_MIN;
        end
        return val_w[`NADC-1:0];
    endfunction

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= adc_i.valid;
        end
    end

    // code payload, one slice per lane
    always_ff @(posedge clk_adc) begin
        for (int k = 0; k < `NTI; k++) begin
            code_q[k] <= unfold_slice(adc_i.slice[k], offset_i);
        end
    end

    assign codes_o.code  = code_q;
    assign codes_o.valid = valid_q;

endmodule

`default_nettype wire

// ==== source/cfg_regs.sv ====
`default_nettype none

`include "dcore_settings.svh"

module cfg_regs (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire logic                  cfg_req_i,
    input  wire dcore_pkg::cfg_cmd_t   cfg_cmd_i,
    output logic                       cfg_ack_o,
    output dcore_pkg::dcore_ctrl_t     ctrl_o
);

    localparam dcore_pkg::dcore_ctrl_t CTRL_RESET = '{
        offset:    '0,
        threshold: '0,
        source:    dcore_pkg::SRC_ADC,
        check_en:  1'b0,
        clear:     1'b0,
        inject:    1'b0
    };

    // four-phase responder takes a command on the edge that raises ack
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            cfg_ack_o <= 1'b0;
            ctrl_o    <= CTRL_RESET;
        end else begin
            // pulses last one cycle only
            ctrl_o.clear  <= 1'b0;
            ctrl_o.inject <= 1'b0;
            if (cfg_req_i && !cfg_ack_o) begin
                cfg_ack_o <= 1'b1;
                case (cfg_cmd_i.op)
                    dcore_pkg::CFG_SET_OFFSET: begin
                        ctrl_o.offset <= cfg_cmd_i.data[`NADC-1:0];
                    end
                    dcore_pkg::CFG_SET_THRESH: begin
                        ctrl_o.threshold <= cfg_cmd_i.data[`NADC-1:0];
                    end
                    dcore_pkg::CFG_SET_SOURCE: begin
                        ctrl_o.source <= dcore_pkg::prbs_src_e'(cfg_cmd_i.data[0]);
                    end
                    dcore_pkg::CFG_CHECK_EN: begin
                        ctrl_o.check_en <= cfg_cmd_i.data[0];
                    end
                    dcore_pkg::CFG_CLEAR_COUNTS: begin
                        ctrl_o.clear <= 1'b1;
                    end
                    dcore_pkg::CFG_INJECT_ERR: begin
                        ctrl_o.inject <= 1'b1;
                    end
                    default: begin
                        // unused opcodes are acknowledged and ignored
                    end
                endcase
            end else if (!cfg_req_i && cfg_ack_o) begin
                cfg_ack_o <= 1'b0;
            end
        end
    end

    // ack only answers a request seen on the previous edge
    ack_rise_needs_req: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        $rose(cfg_ack_o) |-> $past(cfg_req_i)
    );

endmodule

`default_nettype wire

// ==== source/dcore_pkg.sv ====
`default_nettype none

`include "dcore_settings.svh"

package dcore_pkg;

    // one unfolded, offset corrected ADC code
    typedef logic signed [`NADC-1:0] adc_code_t;

    // raw slice as delivered by the analog core
    typedef struct packed {
        logic             sign;
        logic [`NADC-1:0] mag;
    } raw_slice_t;

    typedef struct packed {
        raw_slice_t [`NTI-1:0] slice;
        logic                  valid;
    } raw_frame_t;

    typedef struct packed {
        adc_code_t [`NTI-1:0] code;
        logic                 valid;
    } code_frame_t;

    // bit 0 is the earliest bit in serial order
    typedef logic [`NTI-1:0] bit_word_t;

    typedef struct packed {
        bit_word_t bits;
        logic      valid;
    } bit_frame_t;

    typedef enum logic [2:0] {
        CFG_SET_OFFSET   = 3'd0,
        CFG_SET_THRESH   = 3'd1,
        CFG_SET_SOURCE   = 3'd2,
        CFG_CHECK_EN     = 3'd3,
        CFG_CLEAR_COUNTS = 3'd4,
        CFG_INJECT_ERR   = 3'd5
    } cfg_op_e;

    typedef struct packed {
        cfg_op_e                    op;
        logic [`CFG_DATA_WIDTH-1:0] data;
    } cfg_cmd_t;

    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } prbs_src_e;

    // clear and inject are single cycle pulses, the rest are levels
    typedef struct packed {
        adc_code_t offset;
        adc_code_t threshold;
        prbs_src_e source;
        logic      check_en;
        logic      clear;
        logic      inject;
    } dcore_ctrl_t;

    typedef struct packed {
        logic [`COUNT_WIDTH-1:0] err_count;
        logic [`COUNT_WIDTH-1:0] total_count;
    } check_counts_t;

endpackage

`default_nettype wire

// ==== include/dcore_settings.svh ====
`ifndef DCORE_SETTINGS_SVH
`define DCORE_SETTINGS_SVH

// interleaved ADC slices per clock, also bits per checked word
`define NTI 16

// ADC magnitude width and signed code width
`define NADC 8

// PRBS polynomial order, x^7+x^6+1
`define PRBS_ORDER 7

// error and total bit counters
`define COUNT_WIDTH 32

// payload width of one configuration command
`define CFG_DATA_WIDTH 16

`endif
